//--- src/spiMem_defs.svh
`ifndef SPI_MEM_DEFS_SVH
`define SPI_MEM_DEFS_SVH

// --------------------
// Serial word sizes
// --------------------
`define SPI_ADDR_W 7
`define SPI_DATA_W 8

// Register memory size in bytes.
`define MEM_DEPTH 128

// Index of the last bit in one byte phase.
`define BIT_LAST 7

// Number of stable clk cycles before a conditioner accepts a new level.
`define COND_WAIT 3

`endif

//--- src/spiMemPkg.sv
`include "spiMem_defs.svh"

package spiMemPkg;

  // --------------------
  // Controller states
  // --------------------
  typedef enum logic [2:0] {
    getCmd,
    gotCmd,
    read1,
    read2,
    read3,
    write1,
    write2,
    done
  } fsmStateT;

  // Outputs of one input conditioner.
  typedef struct packed {
    logic level;
    logic posEdge;
    logic negEdge;
  } condT;

  typedef struct packed {
    logic misoEnable;
    logic memWrite;
    logic addrWrite;
    logic srLoad;
  } spiCtrlT;

  // The command byte arrives MSB first, so the address sits above the read bit.
  typedef struct packed {
    logic [`SPI_ADDR_W-1:0] addr;
    logic                   rw;  // 1 means read.
  } cmdT;

endpackage

//--- src/inputConditioner.sv
`timescale 1ns/1ns
`include "spiMem_defs.svh"

module inputConditioner #(
  parameter logic resetLevel = 1'b0
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic            noisy,
  output spiMemPkg::condT cond
);

  localparam int cntWidth = $clog2(`COND_WAIT + 1);
  localparam logic [cntWidth-1:0] waitCount = cntWidth'(`COND_WAIT);

  logic                sync0;
  logic                sync1;
  logic [cntWidth-1:0] stableCnt;
  logic                level;
  logic                prevLevel;

  // --------------------
  // Two-flop synchronizer
  // --------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sync0 <= resetLevel;
      sync1 <= resetLevel;
    end else begin
      sync0 <= noisy;
      sync1 <= sync0;
    end
  end

  // --------------------
  // Debounce
  // --------------------
  // A new level is taken only once it has differed from the accepted one
  // for COND_WAIT cycles in a row.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stableCnt <= '0;
      level     <= resetLevel;
      prevLevel <= resetLevel;
    end else begin
      prevLevel <= level;
      if (sync1 == level) begin
        stableCnt <= '0;  // The glitch ended, so the count starts over.
      end else if (stableCnt == waitCount) begin
        level     <= sync1;
        stableCnt <= '0;
      end else begin
        stableCnt <= stableCnt + cntWidth'(1);
      end
    end
  end

  assign cond.level   = level;
  assign cond.posEdge = level & ~prevLevel;  // High for the first cycle of a new high.
  assign cond.negEdge = ~level & prevLevel;

endmodule

//--- src/spiShifter.sv
`timescale 1ns/1ns
`include "spiMem_defs.svh"

module spiShifter (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   shiftEn,
  input  logic                   serialIn,
  input  logic                   misoTick,
  input  logic                   load,
  input  logic [`SPI_DATA_W-1:0] parIn,
  input  logic                   outEnable,
  output spiMemPkg::cmdT         parOut,
  output logic                   miso,
  output logic                   misoEnable
);

  import spiMemPkg::*;

  logic [`SPI_DATA_W-1:0] shiftReg;

  // --------------------
  // Shift register
  // --------------------
  // A parallel load wins over a shift in the same cycle.
  always_ff @(posedge clk) begin
    if (load) begin
      shiftReg <= parIn;
    end else if (shiftEn) begin
      shiftReg <= {shiftReg[`SPI_DATA_W-2:0], serialIn};  // MSB first.
    end
  end

  assign parOut = cmdT'(shiftReg);

  // --------------------
  // MISO output stage
  // --------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      miso       <= 1'b0;
      misoEnable <= 1'b0;
    end else begin
      misoEnable <= outEnable;
      if (misoTick) begin
        miso <= shiftReg[`SPI_DATA_W-1];  // Mode 0 changes data on the falling edge.
      end
    end
  end

endmodule

//--- src/spiFsm.sv
`timescale 1ns/1ns
`include "spiMem_defs.svh"

module spiFsm (
  input  logic               clk,
  input  logic               arstN,
  input  logic               sClkPosEdge,
  input  logic               csHigh,
  input  logic               rwBit,
  output spiMemPkg::spiCtrlT ctrl
);

  import spiMemPkg::*;

  localparam int cntWidth = $clog2(`BIT_LAST + 1);
  localparam logic [cntWidth-1:0] lastBit = cntWidth'(`BIT_LAST);

  fsmStateT            state;
  logic [cntWidth-1:0] bitCnt;

  // --------------------
  // Transaction sequencer
  // --------------------
  // Byte phases advance on SCLK rising edges. The steps between them are
  // one clk cycle each, so they finish well inside half an SCLK period.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state  <= getCmd;
      bitCnt <= '0;
      ctrl   <= '0;
    end else if (csHigh) begin
      // Chip select went high, so the transfer in progress is dropped.
      state  <= getCmd;
      bitCnt <= '0;
      ctrl   <= '0;
    end else begin
      unique case (state)
        getCmd: begin
          if (sClkPosEdge) begin
            if (bitCnt == lastBit) begin
              bitCnt <= '0;
              state  <= gotCmd;
            end else begin
              bitCnt <= bitCnt + cntWidth'(1);
            end
          end
        end

        gotCmd: begin
          ctrl.addrWrite <= 1'b1;  // The address latch takes it on the next edge.
          state          <= rwBit ? read1 : write1;
        end

        // Read path.
        read1: begin
          ctrl.addrWrite <= 1'b0;
          state          <= read2;
        end

        read2: begin
          ctrl.srLoad     <= 1'b1;
          ctrl.misoEnable <= 1'b1;
          state           <= read3;
        end

        read3: begin
          ctrl.srLoad <= 1'b0;
          if (sClkPosEdge) begin
            if (bitCnt == lastBit) begin
              ctrl.misoEnable <= 1'b0;
              bitCnt          <= '0;
              state           <= done;
            end else begin
              bitCnt <= bitCnt + cntWidth'(1);
            end
          end
        end

        // Write path.
        write1: begin
          ctrl.addrWrite <= 1'b0;
          if (sClkPosEdge) begin
            if (bitCnt == lastBit) begin
              bitCnt <= '0;
              state  <= write2;
            end else begin
              bitCnt <= bitCnt + cntWidth'(1);
            end
          end
        end

        write2: begin
          ctrl.memWrite <= 1'b1;  // All 8 data bits are in the shifter now.
          state         <= done;
        end

        done: begin
          ctrl.memWrite <= 1'b0;  // Wait here for chip select to go high.
        end
      endcase
    end
  end

endmodule

//--- src/dataMemory.sv
`timescale 1ns/1ns
`include "spiMem_defs.svh"

module dataMemory (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   addrWrite,
  input  logic                   memWrite,
  input  logic [`SPI_ADDR_W-1:0] addrIn,
  input  logic [`SPI_DATA_W-1:0] writeData,
  output logic [`SPI_DATA_W-1:0] readData
);

  logic [`SPI_ADDR_W-1:0] addrReg;
  logic [`SPI_DATA_W-1:0] mem [`MEM_DEPTH];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      addrReg <= '0;
    end else if (addrWrite) begin
      addrReg <= addrIn;
    end
  end

  // The whole array comes up as zeros.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (memWrite) begin
      mem[addrReg] <= writeData;
    end
  end

  assign readData = mem[addrReg];  // Ready for the shifter load without a wait state.

endmodule

//--- src/spiMem.sv
`timescale 1ns/1ns
`include "spiMem_defs.svh"

module spiMem (
  input  logic clk,
  input  logic arstN,
  input  logic sClk,
  input  logic csN,
  input  logic mosi,
  output logic miso,
  output logic misoEnable
);

  import spiMemPkg::*;

  condT                   sClkCond;
  condT                   csCond;
  condT                   mosiCond;
  spiCtrlT                ctrl;
  cmdT                    parOut;
  logic [`SPI_DATA_W-1:0] readData;

  // --------------------
  // Input conditioning
  // --------------------
  inputConditioner #(
    .resetLevel(1'b0)
  ) sClkConditioner (
    .clk  (clk),
    .arstN(arstN),
    .noisy(sClk),
    .cond (sClkCond)
  );

  // Chip select idles high.
  inputConditioner #(
    .resetLevel(1'b1)
  ) csConditioner (
    .clk  (clk),
    .arstN(arstN),
    .noisy(csN),
    .cond (csCond)
  );

  inputConditioner #(
    .resetLevel(1'b0)
  ) mosiConditioner (
    .clk  (clk),
    .arstN(arstN),
    .noisy(mosi),
    .cond (mosiCond)
  );

  // --------------------
  // Datapath and control
  // --------------------
  spiShifter shifter (
    .clk       (clk),
    .arstN     (arstN),
    .shiftEn   (sClkCond.posEdge),
    .serialIn  (mosiCond.level),
    .misoTick  (sClkCond.negEdge),
    .load      (ctrl.srLoad),
    .parIn     (readData),
    .outEnable (ctrl.misoEnable),
    .parOut    (parOut),
    .miso      (miso),
    .misoEnable(misoEnable)
  );

  spiFsm controller (
    .clk        (clk),
    .arstN      (arstN),
    .sClkPosEdge(sClkCond.posEdge),
    .csHigh     (csCond.level),
    .rwBit      (parOut.rw),  // Bit 0 of the command byte.
    .ctrl       (ctrl)
  );

  dataMemory memory (
    .clk      (clk),
    .arstN    (arstN),
    .addrWrite(ctrl.addrWrite),
    .memWrite (ctrl.memWrite),
    .addrIn   (parOut.addr),
    .writeData(parOut),
    .readData (readData)
  );

endmodule

//--- tests/spiMemTb.sv
`timescale 1ns/1ns
`include "spiMem_defs.svh"

module spiMemTb;

  localparam int halfPeriod = 20;  // clk cycles per SCLK half period.
  localparam int numTxn     = 111;
  localparam int cycleLimit = numTxn * 18 * 2 * halfPeriod * 3 / 2;

  // Expected misoEnable values for the monitor.
  localparam int enLow  = 0;
  localparam int enHigh = 1;
  localparam int enAny  = 2;

  localparam logic [3:0][`SPI_ADDR_W-1:0] fixedAddr = {7'd85, 7'd42, 7'd127, 7'd0};
  localparam logic [3:0][`SPI_DATA_W-1:0] fixedData = {8'h5A, 8'hA5, 8'hFF, 8'h00};

  logic clk;
  logic arstN;
  logic sClk;
  logic csN;
  logic mosi;
  logic miso;
  logic misoEnable;

  logic [`SPI_DATA_W-1:0] shadow [`MEM_DEPTH];  // Reference copy of the memory.
  logic [`SPI_ADDR_W-1:0] lastReadAddr;
  logic [`SPI_DATA_W-1:0] lastReadData;
  int                     enExpect;
  int                     readSeq;
  int                     checkedSeq;
  int                     readPass;
  int                     readFails;
  int                     enSamples;
  int                     enFails;
  int                     cycleCount;

  spiMem spiMem_inst (
    .clk       (clk),
    .arstN     (arstN),
    .sClk      (sClk),
    .csN       (csN),
    .mosi      (mosi),
    .miso      (miso),
    .misoEnable(misoEnable)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [`SPI_DATA_W-1:0] expectedRead(input logic [`SPI_ADDR_W-1:0] addr);
    return shadow[addr];
  endfunction

  function automatic int totalFails();
    return readFails + enFails;
  endfunction

  // --------------------
  // SPI master
  // --------------------
  // Clocks one mode 0 bit. MOSI is set during the low half and MISO is taken just before the rise.
  task automatic clockBit(input logic txBit, input logic glitch, input int afterRise,
                          output logic rxBit);
    mosi = txBit;
    for (int i = 0; i < halfPeriod; i++) begin
      @(negedge clk);
      if (glitch && i == 8) begin
        sClk = 1'b1;  // Short pulse that the conditioner should reject.
      end
      if (glitch && i == 10) begin
        sClk = 1'b0;
      end
    end
    rxBit    = miso;
    sClk     = 1'b1;
    enExpect = afterRise;
    repeat (halfPeriod) @(negedge clk);
    sClk = 1'b0;
  endtask

  task automatic shiftByte(input logic [7:0] txByte, input int nBits, input logic glitch,
                           input int keepEn, input int afterLast, input int atEnd,
                           output logic [7:0] rxByte);
    logic rxBit;
    rxByte = '0;
    for (int i = 0; i < nBits; i++) begin
      clockBit(txByte[7-i], glitch, (i == nBits - 1) ? afterLast : keepEn, rxBit);
      rxByte = {rxByte[6:0], rxBit};
    end
    enExpect = atEnd;
  endtask

  task automatic endTransfer();
    repeat (halfPeriod) @(negedge clk);
    csN = 1'b1;
    repeat (halfPeriod) @(negedge clk);
  endtask

  // The model only takes the byte when all 8 data bits went out.
  task automatic spiWrite(input logic [`SPI_ADDR_W-1:0] addr, input logic [7:0] data,
                          input int dataBits, input logic glitch);
    logic [7:0] unused;
    csN = 1'b0;
    repeat (10) @(negedge clk);
    shiftByte({addr, 1'b0}, 8, 1'b0, enLow, enLow, enLow, unused);
    shiftByte(data, dataBits, glitch, enLow, enLow, enLow, unused);
    endTransfer();
    if (dataBits == 8) begin
      shadow[addr] = data;
    end
  endtask

  task automatic spiRead(input logic [`SPI_ADDR_W-1:0] addr);
    logic [7:0] unused;
    logic [7:0] rxByte;
    csN = 1'b0;
    repeat (10) @(negedge clk);
    shiftByte({addr, 1'b1}, 8, 1'b0, enLow, enAny, enHigh, unused);
    shiftByte(8'h00, 8, 1'b0, enHigh, enAny, enLow, rxByte);
    lastReadAddr = addr;
    lastReadData = rxByte;
    readSeq++;  // Hands the result to the checker.
    endTransfer();
  endtask

  task automatic reportTest(input string name, input int failsBefore);
    int newFails;
    newFails = totalFails() - failsBefore;
    if (newFails == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, newFails);
    end
  endtask

  // --------------------
  // Checkers
  // --------------------
  always @(posedge clk) begin
    logic [`SPI_DATA_W-1:0] want;
    if (readSeq != checkedSeq) begin
      checkedSeq = readSeq;
      want       = expectedRead(lastReadAddr);
      if (lastReadData !== want) begin
        readFails++;
        $display("[FAIL] t=%0t ns signal=miso addr=0x%02h got=0x%02h expected=0x%02h",
                 $time, lastReadAddr, lastReadData, want);
      end else begin
        readPass++;
      end
    end
  end

  // MISO may only be driven in the data phase of a read.
  always @(posedge clk) begin
    if (arstN && enExpect != enAny) begin
      enSamples++;
      if (misoEnable !== (enExpect == enHigh)) begin
        enFails++;
        $display("[FAIL] t=%0t ns signal=misoEnable got=%b expected=%b",
                 $time, misoEnable, enExpect == enHigh);
      end
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d clk cycles.", cycleLimit);
    $display("CHECKS FAILED");
    $finish;
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [`SPI_ADDR_W-1:0] addr;
    logic [`SPI_ADDR_W-1:0] readAddr;
    int                     failsBefore;
    arstN    = 1'b0;
    sClk     = 1'b0;
    csN      = 1'b1;
    mosi     = 1'b0;
    enExpect = enLow;
    readSeq  = 0;
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      shadow[i] = '0;
    end
    void'($urandom(26));
    repeat (8) @(negedge clk);
    arstN = 1'b1;
    repeat (10) @(negedge clk);

    failsBefore = totalFails();
    for (int i = 0; i < 8; i++) begin
      spiRead(7'($urandom));
    end
    reportTest("1 reset contents", failsBefore);

    // The complement goes in first so that a lost write shows up, even for 8'h00.
    failsBefore = totalFails();
    for (int i = 0; i < 4; i++) begin
      spiWrite(fixedAddr[i], ~fixedData[i], 8, 1'b0);
      spiWrite(fixedAddr[i], fixedData[i], 8, 1'b0);
      spiRead(fixedAddr[i]);
    end
    reportTest("2 write then read", failsBefore);

    // A narrow address range gives overwrites, and reads land on neighbours.
    failsBefore = totalFails();
    for (int i = 0; i < 40; i++) begin
      addr     = 7'(56 + $urandom_range(0, 15));
      readAddr = addr + 7'($urandom_range(0, 2)) - 7'd1;
      spiWrite(addr, 8'($urandom), 8, 1'b0);
      spiRead(readAddr);
    end
    reportTest("3 random traffic", failsBefore);

    failsBefore = totalFails();
    spiWrite(7'd9, 8'hC7, 8, 1'b0);
    spiRead(7'd9);
    reportTest("4 misoEnable window", failsBefore);

    failsBefore = totalFails();
    spiWrite(7'd100, 8'h3C, 8, 1'b0);
    spiWrite(7'd100, 8'hC3, 4, 1'b0);  // Chip select rises after 4 data bits.
    spiRead(7'd100);
    spiWrite(7'd100, 8'h96, 8, 1'b0);
    spiRead(7'd100);
    reportTest("5 abort", failsBefore);

    failsBefore = totalFails();
    for (int i = 0; i < 2; i++) begin
      addr = 7'(20 + i);
      spiWrite(addr, 8'($urandom), 8, 1'b1);
      spiRead(addr);
    end
    reportTest("6 glitch rejection", failsBefore);

    $display("Summary: %0d reads ok, %0d reads wrong, %0d misoEnable samples, %0d bad",
             readPass, readFails, enSamples, enFails);
    if (totalFails() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- spiMem.f
+incdir+src
src/spiMemPkg.sv
src/inputConditioner.sv
src/spiShifter.sv
src/spiFsm.sv
src/dataMemory.sv
src/spiMem.sv
tests/spiMemTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Builds the spiMem testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
buildLog=build.log
simLog=sim.log

verilator --binary --timing -f spiMem.f --top-module spiMemTb \
  -Mdir "$buildDir" -o spiMemSim > "$buildLog" 2>&1 \
  || { cat "$buildLog"; echo "Verilator build failed."; exit 1; }

"./$buildDir/spiMemSim" > "$simLog" 2>&1 ; cat "$simLog"

grep -q "ALL CHECKS PASSED" "$simLog" \
  && echo "Simulation result: pass." \
  && exit 0 \
  || { echo "Simulation result: fail, see $simLog."; exit 1; }
